/* Makefile */
# Verilator build and run of the word receiver testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= word_receiver_tb
FILELIST  ?= word_receiver.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Regression passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables:"
	@echo "  VERILATOR  simulator command    ($(VERILATOR))"
	@echo "  TOP        testbench top module ($(TOP))"
	@echo "  FILELIST   source file list     ($(FILELIST))"
	@echo "  OBJ_DIR    build directory      ($(OBJ_DIR))"
	@echo "  VFLAGS     Verilator options    ($(VFLAGS))"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_TEXT)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

/* logic/align_pkg.sv */
package align_pkg;

	// word alignment state machine
	// hunt       compare each captured word with the training word
	// slip_wait  let the counter settle after a bitslip
	// verify     count consecutive matches before trusting the boundary
	// locked     aligned, words are passed on until rst or realign
	typedef enum logic [1:0] {
		hunt      = 2'd0,
		slip_wait = 2'd1,
		verify    = 2'd2,
		locked    = 2'd3
	} align_state_t;

	localparam int lock_matches = 4; // consecutive matches needed for lock
	localparam int settle_words = 2; // strobes skipped after each slip

	localparam int slip_count_width = 4; // slips seen since rst, saturating

	// counter widths derived from the limits above
	localparam int match_width = $clog2(lock_matches + 1);
	localparam int settle_width = $clog2(settle_words + 1);

endpackage

/* logic/alignment_fsm.sv */
module alignment_fsm (
	input  logic clock,
	input  logic rst,
	input  logic realign,                    // drop lock and hunt again
	input  logic captured_strobe,            // new word from the deserializer
	input  serdes_pkg::word_t captured_word,
	output logic bitslip,                    // one-cycle slip request to the counter
	output logic locked,                     // boundary found and verified
	output logic [align_pkg::slip_count_width-1:0] slip_count // slips since rst
);
	import serdes_pkg::*;
	import align_pkg::*;

	align_state_t state;
	logic [match_width-1:0] match_count;   // consecutive training words seen
	logic [settle_width-1:0] settle_count; // strobes skipped since the slip

	logic word_match; // captured word is the training word
	logic comparing;  // states that judge each captured word
	logic slip_now;   // mismatch seen on this strobe
	logic last_match; // this match completes the verify run
	logic last_settle;

	assign word_match = (captured_word == training_word);
	assign comparing = (state == hunt) || (state == verify);
	// realign in the same cycle wins over a slip
	assign slip_now = captured_strobe && comparing && !word_match && !realign;
	assign last_match = (match_count == match_width'(lock_matches - 1));
	assign last_settle = (settle_count == settle_width'(settle_words - 1));

	// next state, lock flag and the two counters
	always_ff @(posedge clock) begin
		if (rst) begin
			state <= hunt;
			locked <= 1'b0;
			match_count <= '0;
			settle_count <= '0;
		end else if (realign) begin
			state <= hunt; // slip_count is kept
			locked <= 1'b0;
			match_count <= '0;
			settle_count <= '0;
		end else if (captured_strobe) begin
			case (state)
				hunt: begin
					if (word_match) begin
						state <= verify;
						match_count <= match_width'(1); // this word counts
					end else begin
						state <= slip_wait;
						settle_count <= '0;
					end
				end
				slip_wait: begin
					if (last_settle) begin
						state <= hunt;
					end else begin
						settle_count <= settle_count + 1'b1;
					end
				end
				verify: begin
					if (!word_match) begin
						state <= slip_wait; // false start, slip again
						settle_count <= '0;
						match_count <= '0;
					end else if (last_match) begin
						state <= align_pkg::locked;
						locked <= 1'b1;
					end else begin
						match_count <= match_count + 1'b1;
					end
				end
				default: begin
					state <= align_pkg::locked; // stays here until rst or realign
				end
			endcase
		end
	end

	// slip pulse goes out the cycle after the mismatching strobe
	always_ff @(posedge clock) begin
		if (rst) begin
			bitslip <= 1'b0;
		end else begin
			bitslip <= slip_now;
		end
	end

	// running slip total, sticks at all ones
	always_ff @(posedge clock) begin
		if (rst) begin
			slip_count <= '0;
		end else if (slip_now && (slip_count != '1)) begin
			slip_count <= slip_count + 1'b1;
		end
	end

	a_no_slip_when_locked: assert property (
		@(posedge clock) disable iff (rst)
		(state == align_pkg::locked) |-> !bitslip
	) else $error("bitslip issued while locked");

	a_locked_matches_state: assert property (
		@(posedge clock) disable iff (rst)
		locked == (state == align_pkg::locked)
	) else $error("locked output out of step with state");

	// only rst may bring the count down
	a_slip_count_monotonic: assert property (
		@(posedge clock) disable iff (rst)
		!$past(rst) |-> (slip_count >= $past(slip_count))
	) else $error("slip_count decreased without rst");

endmodule

/* logic/bit_counter.sv */
module bit_counter (
	input  logic clock,
	input  logic rst,
	input  logic bitslip,       // one-cycle request to move the boundary by one bit
	output logic word_boundary  // high while the tenth bit of a word is on input_bit
);
	import serdes_pkg::*;

	logic [count_width-1:0] count; // position of the current bit in its word
	logic slip_pending;            // slip requested, not yet applied
	logic hold;                    // extra bit time on this clock

	// slip is applied at the start of a word period
	// the counter stays at zero for one extra clock, so that period lasts
	// eleven bits and every later boundary lands one bit later in the stream
	assign hold = slip_pending && (count == '0);

	// decode of the counter register, no extra latency
	assign word_boundary = (count == count_width'(last_bit));

	always_ff @(posedge clock) begin
		if (rst) begin
			count <= '0;
			slip_pending <= 1'b0;
		end else begin
			if (hold) begin
				slip_pending <= 1'b0; // consumed, zero repeats once
			end else if (bitslip) begin
				slip_pending <= 1'b1;
			end
			if (hold) begin
				count <= count; // stretched period
			end else if (word_boundary) begin
				count <= '0; // wrap after bit nine
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// the state machine waits out settle_words strobes after each slip,
	// which is longer than a pending slip can last
	// a second request here would be lost
	a_no_slip_while_pending: assert property (
		@(posedge clock) disable iff (rst)
		bitslip |-> !slip_pending
	) else $error("bitslip while a slip is still pending");

endmodule

/* logic/bit_deserializer.sv */
module bit_deserializer (
	input  logic clock,
	input  logic rst,
	input  logic input_bit,              // serial data, one bit per clock
	input  logic word_boundary,          // current bit closes a word
	output serdes_pkg::word_t captured_word, // last complete word
	output logic captured_strobe         // captured_word was just updated
);
	import serdes_pkg::*;

	logic [word_width-2:0] shift_reg; // the nine bits before the current one
	word_t assembled;                 // ten newest bits, current bit at lsb

	// older bits move toward the msb, so the first bit of a word
	// ends up in bit 9 once the tenth has arrived
	assign assembled = {shift_reg, input_bit};

	// free-running shifter, no framing of its own
	always_ff @(posedge clock) begin
		shift_reg <= assembled[word_width-2:0];
	end

	// parallel register, loaded with the bit of the boundary cycle included
	always_ff @(posedge clock) begin
		if (word_boundary) begin
			captured_word <= assembled;
		end
	end

	// strobe lines up with the new captured_word
	always_ff @(posedge clock) begin
		if (rst) begin
			captured_strobe <= 1'b0;
		end else begin
			captured_strobe <= word_boundary;
		end
	end

	// boundaries come at least ten clocks apart, even around a slip
	a_strobe_single: assert property (
		@(posedge clock) disable iff (rst)
		captured_strobe |=> !captured_strobe
	) else $error("captured_strobe high on two consecutive cycles");

endmodule

/* logic/serdes_pkg.sv */
package serdes_pkg;

	// serial link framing
	// one bit arrives per rising edge of clock, ten bits make one word

	localparam int word_width = 10; // bits per parallel word
	localparam int count_width = 4; // bit counter, holds 0..9

	// parallel word as seen at the receiver output
	// first bit on the wire lands in bit 9, last bit in bit 0
	typedef logic [word_width-1:0] word_t;

	// training pattern sent by the far end while the receiver aligns
	// five ones then five zeros
	// every rotation of it is a different value, so a match means the
	// boundary sits at exactly one bit position
	localparam word_t training_word = 10'b11111_00000;

	// the counter has to reach word_width-1
	// a narrower setting would never produce a boundary
	localparam int last_bit = word_width - 1; // count value of the final bit

endpackage

/* logic/word_receiver.sv */
module word_receiver (
	input  logic clock,      // bit rate clock
	input  logic rst,
	input  logic input_bit,  // serial stream
	input  logic realign,    // strobe, restart alignment
	output serdes_pkg::word_t output_word,
	output logic word_valid, // one pulse per word once locked
	output logic locked,
	output logic [align_pkg::slip_count_width-1:0] slip_count
);
	import serdes_pkg::*;

	logic word_boundary;   // counter to deserializer
	logic bitslip;         // state machine back to counter
	word_t captured_word;
	logic captured_strobe;

	// framing, every tenth bit closes a word
	bit_counter i_bit_counter (
		.clock         (clock),
		.rst           (rst),
		.bitslip       (bitslip),
		.word_boundary (word_boundary)
	);

	// serial to parallel
	bit_deserializer i_bit_deserializer (
		.clock           (clock),
		.rst             (rst),
		.input_bit       (input_bit),
		.word_boundary   (word_boundary),
		.captured_word   (captured_word),
		.captured_strobe (captured_strobe)
	);

	// training word search and lock
	alignment_fsm i_alignment_fsm (
		.clock           (clock),
		.rst             (rst),
		.realign         (realign),
		.captured_strobe (captured_strobe),
		.captured_word   (captured_word),
		.bitslip         (bitslip),
		.locked          (locked),
		.slip_count      (slip_count)
	);

	assign output_word = captured_word;
	// words before lock are training or misframed, held back here
	assign word_valid = captured_strobe && locked;

endmodule

/* verif/word_receiver_tb.sv */
module word_receiver_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import serdes_pkg::*;
	import align_pkg::*;

	localparam int timeout_cycles = 2000; // limit for every wait loop
	localparam int trials = 4;            // alignment runs, each from reset
	localparam int realigns = 3;          // fewest relocks, more follow until saturation
	localparam int count_max = (1 << slip_count_width) - 1;

	logic clock;
	logic rst;
	logic input_bit;
	logic realign;
	word_t output_word;
	logic word_valid;
	logic locked;
	logic [slip_count_width-1:0] slip_count;

	integer seed;                                 // $random state
	word_t expected[$];                           // words due at output_word, oldest first
	int cycle_count;                              // counted on falling edges
	int last_valid_cycle;                         // -1 until a word_valid in this lock
	logic [slip_count_width-1:0] expected_slips;  // reference total since rst

	word_receiver i_dut (
		.clock       (clock),
		.rst         (rst),
		.input_bit   (input_bit),
		.realign     (realign),
		.output_word (output_word),
		.word_valid  (word_valid),
		.locked      (locked),
		.slip_count  (slip_count)
	);

	always begin
		#5 clock = ~clock; // 10 ns bit period
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t actual, input word_t wanted);
		if (actual !== wanted) begin
			report_failure($sformatf("ERROR t=%0t %s expected %h got %h",
				$time, name, wanted, actual));
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic wanted);
		if (actual !== wanted) begin
			report_failure($sformatf("ERROR t=%0t %s expected %b got %b",
				$time, name, wanted, actual));
		end
	endtask

	task automatic check_count(input string name,
			input logic [slip_count_width-1:0] actual,
			input logic [slip_count_width-1:0] wanted);
		if (actual !== wanted) begin
			report_failure($sformatf("ERROR t=%0t %s expected %0d got %0d",
				$time, name, wanted, actual));
		end
	endtask

	task automatic check_gap(input string name, input int actual, input int wanted);
		if (actual != wanted) begin
			report_failure($sformatf("ERROR t=%0t %s expected %0d got %0d",
				$time, name, wanted, actual));
		end
	endtask

	// expected slip total once the boundary has caught up with a stream that
	// runs shift bits behind it
	// each slip pushes the boundary one bit later, so the count is the
	// smallest s from zero up for which shift minus s is a whole number of words
	function automatic logic [slip_count_width-1:0] slips_after(
			input logic [slip_count_width-1:0] prior, input int shift);
		int s;
		int total;
		s = 0;
		while (((shift - s) % word_width) != 0) begin
			s++;
		end
		total = int'(prior) + s;
		if (total > count_max) begin
			total = count_max; // counter sticks at all ones
		end
		return slip_count_width'(total);
	endfunction

	// true for the training word at any of its ten phases
	function automatic logic is_rotation(input word_t w);
		logic [2*word_width-1:0] doubled;
		doubled = {training_word, training_word};
		for (int r = 0; r < word_width; r++) begin
			if (w == doubled[r +: word_width]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// one bit per clock, changed 1 ns after the edge
	task automatic send_bit(input logic b);
		input_bit = b;
		@(posedge clock);
		#1;
		realign = 1'b0; // strobe lasts one edge
	endtask

	// msb first; a word is expected at the output when lock is already up
	// while its last bit goes out, its strobe comes one clock later
	task automatic send_word(input word_t w);
		for (int i = word_width - 1; i >= 0; i--) begin
			if ((i == 0) && locked) begin
				expected.push_back(w);
			end
			send_bit(w[i]);
		end
	endtask

	task automatic send_filler(input int n);
		logic b;
		for (int i = 0; i < n; i++) begin
			b = 1'($random(seed));
			send_bit(b);
		end
	endtask

	task automatic send_data(input int n);
		word_t w;
		for (int i = 0; i < n; i++) begin
			w = word_t'($random(seed));
			send_word(w);
		end
	endtask

	task automatic train_until_locked(input string phase);
		int waited;
		waited = 0;
		while (!locked) begin
			if (waited >= timeout_cycles) begin
				report_failure($sformatf("locked never rose within the timeout during %s",
					phase));
			end
			send_word(training_word);
			waited += word_width;
		end
	endtask

	task automatic wait_for_drain();
		int waited;
		waited = 0;
		while (expected.size() != 0) begin
			if (waited >= timeout_cycles) begin
				report_failure("sent data words never appeared at output_word");
			end
			@(posedge clock);
			#1;
			waited++;
		end
	endtask

	// ten clocks of rst, then the stream may start right away
	task automatic apply_reset();
		wait_for_drain();
		rst = 1'b1;
		input_bit = 1'b0;
		realign = 1'b0;
		repeat (10) @(posedge clock);
		#1;
		rst = 1'b0;
		check_flag("locked", locked, 1'b0);
		check_flag("word_valid", word_valid, 1'b0);
		check_count("slip_count", slip_count, '0);
	endtask

	// output side, checked on the falling edge
	always @(negedge clock) begin
		word_t wanted;
		cycle_count++;
		if (!locked) begin
			last_valid_cycle = -1; // spacing restarts with each lock
		end
		if (word_valid === 1'b1) begin
			if (expected.size() == 0) begin
				report_failure($sformatf("word_valid pulsed at %0t with no word expected",
					$time));
			end
			wanted = expected.pop_front();
			check_word("output_word", output_word, wanted);
			if (last_valid_cycle >= 0) begin
				check_gap("word_valid spacing", cycle_count - last_valid_cycle, word_width);
			end
			last_valid_cycle = cycle_count;
		end
	end

	initial begin
		int offset;
		int shift;
		int runs;
		logic saturated;
		word_t w;
		seed = 9514;
		clock = 1'b0;
		rst = 1'b1;
		input_bit = 1'b0;
		realign = 1'b0;
		cycle_count = 0;
		last_valid_cycle = -1;

		// lock from reset at random phases, then data words
		for (int t = 0; t < trials; t++) begin
			apply_reset();
			offset = $unsigned($random(seed)) % word_width;
			send_filler(offset);
			train_until_locked("alignment");
			expected_slips = slips_after('0, offset);
			check_count("slip_count", slip_count, expected_slips);
			send_data(8);
		end

		// lock needs four training words in a row at one phase
		apply_reset();
		for (int n = 0; n < 60; n++) begin
			w = word_t'($random(seed));
			if (!is_rotation(w)) begin
				send_word(w);
				check_flag("locked", locked, 1'b0);
			end
		end

		// realign with the stream moved by a fresh offset each time
		// more rounds follow until the slip counter has had to stick at its top
		apply_reset();
		offset = $unsigned($random(seed)) % word_width;
		send_filler(offset);
		train_until_locked("realign setup");
		expected_slips = slips_after('0, offset);
		check_count("slip_count", slip_count, expected_slips);
		runs = 0;
		saturated = 1'b0;
		while ((runs < realigns) || !saturated) begin
			send_word(training_word);
			send_word(training_word);
			shift = 1 + ($unsigned($random(seed)) % (word_width - 1));
			realign = 1'b1;
			send_bit(1'b0);   // zeros never complete a false training word
			check_flag("locked", locked, 1'b0);
			for (int i = 1; i < shift; i++) begin
				send_bit(1'b0);
			end
			train_until_locked("relock");
			if ((int'(expected_slips) + shift) > count_max) begin
				saturated = 1'b1; // this relock runs past the counter limit
			end
			expected_slips = slips_after(expected_slips, shift);
			check_count("slip_count", slip_count, expected_slips);
			send_data(6);
			runs++;
		end

		wait_for_drain();
		$display("Regression passed");
		$finish;
	end

endmodule

/* word_receiver.f */
logic/serdes_pkg.sv
logic/align_pkg.sv
logic/bit_counter.sv
logic/bit_deserializer.sv
logic/alignment_fsm.sv
logic/word_receiver.sv
verif/word_receiver_tb.sv
